// ==== build.f ====
+incdir+tb
hw/core_pkg.sv
hw/core_if.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core.sv
tb/tb_rv_core.sv

// ==== hw/core_if.sv ====
`timescale 1ns/1ns

// Decode to execute register contents
interface id_ex_if;
  logic                 valid;
  core_pkg::xlen_t      pc;
  core_pkg::xlen_t      rs1_val;
  core_pkg::xlen_t      rs2_val;
  core_pkg::xlen_t      imm;
  core_pkg::reg_addr_t  rs1_addr;
  core_pkg::reg_addr_t  rs2_addr;
  core_pkg::reg_addr_t  rd_addr;
  logic                 reg_we;
  core_pkg::alu_op_e    alu_op;
  logic                 use_imm;
  logic                 is_load;
  logic                 is_store;
  logic                 is_branch;
  logic                 branch_ne;
  logic                 is_jal;
  core_pkg::wb_sel_e    wb_sel;

  modport producer (
    output valid, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr,
    output reg_we, alu_op, use_imm, is_load, is_store, is_branch, branch_ne,
    output is_jal, wb_sel
  );

  modport consumer (
    input valid, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr,
    input reg_we, alu_op, use_imm, is_load, is_store, is_branch, branch_ne,
    input is_jal, wb_sel
  );

  // Load-use detection only looks at the destination of a load
  modport monitor (input valid, rd_addr, reg_we, is_load);
endinterface

// Execute to memory register contents
interface ex_mem_if;
  logic                 valid;
  core_pkg::xlen_t      alu_result;
  core_pkg::xlen_t      pc4;
  core_pkg::xlen_t      store_data;
  core_pkg::reg_addr_t  rd_addr;
  logic                 reg_we;
  logic                 is_load;
  logic                 is_store;
  core_pkg::wb_sel_e    wb_sel;

  modport producer (
    output valid, alu_result, pc4, store_data, rd_addr, reg_we, is_load, is_store, wb_sel
  );

  modport consumer (
    input valid, alu_result, pc4, store_data, rd_addr, reg_we, is_load, is_store, wb_sel
  );
endinterface

// ==== hw/core_pkg.sv ====
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // ALU operations, PASS_B carries the LUI immediate through
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Source of the register writeback value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam xlen_t RESET_PC = 32'h0000_0000;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_stall,
  input  logic                i_flush,
  input  logic                i_if_valid,
  input  core_pkg::xlen_t     i_if_pc,
  input  core_pkg::inst_t     i_if_inst,
  output core_pkg::reg_addr_t o_rs1_addr,
  output core_pkg::reg_addr_t o_rs2_addr,
  input  logic                i_wb_we,
  input  core_pkg::reg_addr_t i_wb_rd,
  input  core_pkg::xlen_t     i_wb_data,
  id_ex_if.producer           id_ex
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  core_pkg::xlen_t imm_i;
  core_pkg::xlen_t imm_s;
  core_pkg::xlen_t imm_b;
  core_pkg::xlen_t imm_u;
  core_pkg::xlen_t imm_j;
  core_pkg::xlen_t rs1_val;
  core_pkg::xlen_t rs2_val;

  logic legal;
  logic use_rs1;
  logic use_rs2;
  logic reg_we;
  logic use_imm;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jal;
  logic take;
  core_pkg::alu_op_e alu_op;
  core_pkg::wb_sel_e wb_sel;
  core_pkg::xlen_t   imm;

  assign opcode = i_if_inst[6:0];
  assign funct3 = i_if_inst[14:12];
  assign funct7 = i_if_inst[31:25];

  assign imm_i = {{20{i_if_inst[31]}}, i_if_inst[31:20]};
  assign imm_s = {{20{i_if_inst[31]}}, i_if_inst[31:25], i_if_inst[11:7]};
  assign imm_b = {{19{i_if_inst[31]}}, i_if_inst[31], i_if_inst[7],
                  i_if_inst[30:25], i_if_inst[11:8], 1'b0};
  assign imm_u = {i_if_inst[31:12], 12'b0};
  assign imm_j = {{11{i_if_inst[31]}}, i_if_inst[31], i_if_inst[19:12],
                  i_if_inst[20], i_if_inst[30:21], 1'b0};

  always_comb begin
    legal     = 1'b1;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    reg_we    = 1'b0;
    use_imm   = 1'b1;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    alu_op    = core_pkg::ALU_ADD;
    wb_sel    = core_pkg::WB_ALU;
    imm       = imm_i;
    case (opcode)
      core_pkg::OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        reg_we  = 1'b1;
        use_imm = 1'b0;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = core_pkg::ALU_AND;
          {7'b0000000, 3'b110}: alu_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b100}: alu_op = core_pkg::ALU_XOR;
          {7'b0000000, 3'b010}: alu_op = core_pkg::ALU_SLT;
          default:              legal  = 1'b0;
        endcase
      end
      core_pkg::OPC_OPIMM: begin
        // ADDI only
        use_rs1 = 1'b1;
        reg_we  = 1'b1;
        legal   = (funct3 == 3'b000);
      end
      core_pkg::OPC_LUI: begin
        reg_we = 1'b1;
        alu_op = core_pkg::ALU_PASS_B;
        imm    = imm_u;
      end
      core_pkg::OPC_LOAD: begin
        use_rs1 = 1'b1;
        reg_we  = 1'b1;
        is_load = 1'b1;
        wb_sel  = core_pkg::WB_MEM;
        legal   = (funct3 == 3'b010);
      end
      core_pkg::OPC_STORE: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        is_store = 1'b1;
        imm      = imm_s;
        legal    = (funct3 == 3'b010);
      end
      core_pkg::OPC_BRANCH: begin
        // BEQ and BNE
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        use_imm   = 1'b0;
        is_branch = 1'b1;
        imm       = imm_b;
        legal     = (funct3[2:1] == 2'b00);
      end
      core_pkg::OPC_JAL: begin
        reg_we = 1'b1;
        is_jal = 1'b1;
        wb_sel = core_pkg::WB_PC4;
        imm    = imm_j;
      end
      default: legal = 1'b0;
    endcase
  end

  // Unused source fields read as x0 so they never forward or stall
  assign o_rs1_addr = (legal && use_rs1) ? i_if_inst[19:15] : '0;
  assign o_rs2_addr = (legal && use_rs2) ? i_if_inst[24:20] : '0;

  register_file i_register_file (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (i_wb_we),
    .i_waddr    (i_wb_rd),
    .i_wdata    (i_wb_data),
    .i_rs1_addr (o_rs1_addr),
    .i_rs2_addr (o_rs2_addr),
    .o_rs1      (rs1_val),
    .o_rs2      (rs2_val)
  );

  // Stall, flush and unsupported encodings all become bubbles
  assign take = i_if_valid && legal && !i_stall && !i_flush;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      id_ex.valid     <= 1'b0;
      id_ex.reg_we    <= 1'b0;
      id_ex.is_load   <= 1'b0;
      id_ex.is_store  <= 1'b0;
      id_ex.is_branch <= 1'b0;
      id_ex.is_jal    <= 1'b0;
    end else begin
      id_ex.valid     <= take;
      id_ex.reg_we    <= take && reg_we;
      id_ex.is_load   <= take && is_load;
      id_ex.is_store  <= take && is_store;
      id_ex.is_branch <= take && is_branch;
      id_ex.is_jal    <= take && is_jal;
    end
  end

  always_ff @(posedge i_clk) begin
    id_ex.pc        <= i_if_pc;
    id_ex.rs1_val   <= rs1_val;
    id_ex.rs2_val   <= rs2_val;
    id_ex.imm       <= imm;
    id_ex.rs1_addr  <= o_rs1_addr;
    id_ex.rs2_addr  <= o_rs2_addr;
    id_ex.rd_addr   <= i_if_inst[11:7];
    id_ex.alu_op    <= alu_op;
    id_ex.use_imm   <= use_imm;
    id_ex.branch_ne <= funct3[0];
    id_ex.wb_sel    <= wb_sel;
  end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic                i_clk,
  input  logic                i_rst_n,
  id_ex_if.consumer           id_ex,
  input  logic                i_wb_we,
  input  core_pkg::reg_addr_t i_wb_rd,
  input  core_pkg::xlen_t     i_wb_data,
  output logic                o_redirect,
  output core_pkg::xlen_t     o_redirect_pc,
  ex_mem_if.producer          ex_mem
);

  core_pkg::xlen_t mem_fwd_val;
  core_pkg::xlen_t rs1_fwd;
  core_pkg::xlen_t rs2_fwd;
  core_pkg::xlen_t op_b;
  core_pkg::xlen_t alu_res;
  logic            eq;

  // EX/MEM holds the younger result so it takes priority
  function automatic core_pkg::xlen_t forward(input core_pkg::reg_addr_t addr,
                                              input core_pkg::xlen_t rf_val);
    core_pkg::xlen_t val;
    val = rf_val;
    if (addr != '0) begin
      if (ex_mem.valid && ex_mem.reg_we && ex_mem.rd_addr == addr) begin
        val = mem_fwd_val;
      end else if (i_wb_we && i_wb_rd == addr) begin
        val = i_wb_data;
      end
    end
    return val;
  endfunction

  // Load data is never forwarded from here, the load-use stall covers it
  assign mem_fwd_val = (ex_mem.wb_sel == core_pkg::WB_PC4) ? ex_mem.pc4 : ex_mem.alu_result;

  always_comb begin
    rs1_fwd = forward(id_ex.rs1_addr, id_ex.rs1_val);
    rs2_fwd = forward(id_ex.rs2_addr, id_ex.rs2_val);
  end

  assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.alu_op)
      core_pkg::ALU_ADD: alu_res = rs1_fwd + op_b;
      core_pkg::ALU_SUB: alu_res = rs1_fwd - op_b;
      core_pkg::ALU_AND: alu_res = rs1_fwd & op_b;
      core_pkg::ALU_OR:  alu_res = rs1_fwd | op_b;
      core_pkg::ALU_XOR: alu_res = rs1_fwd ^ op_b;
      core_pkg::ALU_SLT: alu_res = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
      default:           alu_res = op_b;
    endcase
  end

  // Branch decision
  assign eq = (rs1_fwd == rs2_fwd);
  assign o_redirect = id_ex.valid &&
                      (id_ex.is_jal || (id_ex.is_branch && (eq != id_ex.branch_ne)));
  assign o_redirect_pc = id_ex.pc + id_ex.imm;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ex_mem.valid    <= 1'b0;
      ex_mem.reg_we   <= 1'b0;
      ex_mem.is_load  <= 1'b0;
      ex_mem.is_store <= 1'b0;
    end else begin
      ex_mem.valid    <= id_ex.valid;
      ex_mem.reg_we   <= id_ex.reg_we;
      ex_mem.is_load  <= id_ex.is_load;
      ex_mem.is_store <= id_ex.is_store;
    end
  end

  always_ff @(posedge i_clk) begin
    ex_mem.alu_result <= alu_res;
    ex_mem.pc4        <= id_ex.pc + 32'd4;
    ex_mem.store_data <= rs2_fwd;
    ex_mem.rd_addr    <= id_ex.rd_addr;
    ex_mem.wb_sel     <= id_ex.wb_sel;
  end

  // Taken branch must have been a real instruction, and the next slot is a bubble
  a_redirect_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_redirect |-> id_ex.valid ##1 !id_ex.valid);

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_stall,
  input  logic            i_flush,
  input  logic            i_redirect,
  input  core_pkg::xlen_t i_redirect_pc,
  output core_pkg::xlen_t o_imem_addr,
  input  core_pkg::inst_t i_imem_data,
  output logic            o_if_valid,
  output core_pkg::xlen_t o_if_pc,
  output core_pkg::inst_t o_if_inst
);

  core_pkg::xlen_t pc_q;

  assign o_imem_addr = pc_q;

  // Redirect wins over the load-use hold
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q <= core_pkg::RESET_PC;
    end else if (i_redirect) begin
      pc_q <= i_redirect_pc;
    end else if (!i_stall) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // IF/ID valid
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_if_valid <= 1'b0;
    end else if (i_flush) begin
      o_if_valid <= 1'b0;
    end else if (!i_stall) begin
      o_if_valid <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge i_clk) begin
    if (i_flush) begin
      o_if_inst <= core_pkg::NOP_INST;
    end else if (!i_stall) begin
      o_if_pc   <= pc_q;
      o_if_inst <= i_imem_data;
    end
  end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
  input  core_pkg::reg_addr_t i_rs1_addr,
  input  core_pkg::reg_addr_t i_rs2_addr,
  id_ex_if.monitor            id_ex,
  input  logic                i_redirect,
  output logic                o_stall,
  output logic                o_flush
);

  logic load_in_ex;
  logic load_use;

  // Load result is not ready until writeback
  assign load_in_ex = id_ex.valid && id_ex.is_load && id_ex.reg_we && (id_ex.rd_addr != '0);
  assign load_use   = load_in_ex &&
                      ((id_ex.rd_addr == i_rs1_addr) || (id_ex.rd_addr == i_rs2_addr));

  // Redirect kills the decoding instruction anyway
  assign o_stall = load_use && !i_redirect;
  assign o_flush = i_redirect;

  always_comb begin
    a_stall_needs_load: assert final (!o_stall || (id_ex.valid && id_ex.is_load && !o_flush));
  end

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic                i_clk,
  input  logic                i_rst_n,
  ex_mem_if.consumer          ex_mem,
  output core_pkg::xlen_t     o_dmem_addr,
  output logic                o_dmem_we,
  output core_pkg::xlen_t     o_dmem_wdata,
  input  core_pkg::xlen_t     i_dmem_rdata,
  output logic                o_wb_we,
  output core_pkg::reg_addr_t o_wb_rd,
  output core_pkg::xlen_t     o_wb_data
);

  logic                we_q;
  core_pkg::reg_addr_t rd_q;
  core_pkg::wb_sel_e   sel_q;
  core_pkg::xlen_t     alu_q;
  core_pkg::xlen_t     pc4_q;
  core_pkg::xlen_t     rdata_q;

  assign o_dmem_addr  = ex_mem.alu_result;
  assign o_dmem_wdata = ex_mem.store_data;
  assign o_dmem_we    = ex_mem.valid && ex_mem.is_store;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      we_q <= 1'b0;
    end else begin
      we_q <= ex_mem.valid && ex_mem.reg_we;
    end
  end

  // MEM/WB payload
  always_ff @(posedge i_clk) begin
    rd_q  <= ex_mem.rd_addr;
    sel_q <= ex_mem.wb_sel;
    alu_q <= ex_mem.alu_result;
    pc4_q <= ex_mem.pc4;
    if (ex_mem.is_load) begin
      rdata_q <= i_dmem_rdata;
    end
  end

  always_comb begin
    case (sel_q)
      core_pkg::WB_MEM: o_wb_data = rdata_q;
      core_pkg::WB_PC4: o_wb_data = pc4_q;
      default:          o_wb_data = alu_q;
    endcase
  end

  assign o_wb_we = we_q;
  assign o_wb_rd = rd_q;

  // A store never writes a register on the following writeback
  a_store_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_dmem_we |-> ex_mem.valid ##1 !o_wb_we);

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_we,
  input  core_pkg::reg_addr_t i_waddr,
  input  core_pkg::xlen_t     i_wdata,
  input  core_pkg::reg_addr_t i_rs1_addr,
  input  core_pkg::reg_addr_t i_rs2_addr,
  output core_pkg::xlen_t     o_rs1,
  output core_pkg::xlen_t     o_rs2
);

  // x0 has no storage
  core_pkg::xlen_t regs [1:31];

  logic write_ok;

  assign write_ok = i_rst_n && i_we && (i_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (write_ok) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Write-first bypass so writeback and decode can share a cycle
  assign o_rs1 = (i_rs1_addr == '0) ? '0 :
                 (write_ok && i_waddr == i_rs1_addr) ? i_wdata : regs[i_rs1_addr];
  assign o_rs2 = (i_rs2_addr == '0) ? '0 :
                 (write_ok && i_waddr == i_rs2_addr) ? i_wdata : regs[i_rs2_addr];

  a_x0_rs1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rs1_addr == '0 |-> o_rs1 == '0);
  a_x0_rs2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rs2_addr == '0 |-> o_rs2 == '0);

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns

module rv_core (
  input  logic            i_clk,
  input  logic            i_rst_n,
  output core_pkg::xlen_t o_imem_addr,
  input  core_pkg::inst_t i_imem_data,
  output core_pkg::xlen_t o_dmem_addr,
  output logic            o_dmem_we,
  output core_pkg::xlen_t o_dmem_wdata,
  input  core_pkg::xlen_t i_dmem_rdata
);

  logic                if_valid;
  core_pkg::xlen_t     if_pc;
  core_pkg::inst_t     if_inst;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  logic                stall;
  logic                flush;
  logic                redirect;
  core_pkg::xlen_t     redirect_pc;
  logic                wb_we;
  core_pkg::reg_addr_t wb_rd;
  core_pkg::xlen_t     wb_data;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage i_fetch_stage (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_stall       (stall),
    .i_flush       (flush),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_imem_addr   (o_imem_addr),
    .i_imem_data   (i_imem_data),
    .o_if_valid    (if_valid),
    .o_if_pc       (if_pc),
    .o_if_inst     (if_inst)
  );

  decode_stage i_decode_stage (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_stall    (stall),
    .i_flush    (flush),
    .i_if_valid (if_valid),
    .i_if_pc    (if_pc),
    .i_if_inst  (if_inst),
    .o_rs1_addr (rs1_addr),
    .o_rs2_addr (rs2_addr),
    .i_wb_we    (wb_we),
    .i_wb_rd    (wb_rd),
    .i_wb_data  (wb_data),
    .id_ex      (id_ex.producer)
  );

  hazard_unit i_hazard_unit (
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .id_ex      (id_ex.monitor),
    .i_redirect (redirect),
    .o_stall    (stall),
    .o_flush    (flush)
  );

  execute_stage i_execute_stage (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .id_ex         (id_ex.consumer),
    .i_wb_we       (wb_we),
    .i_wb_rd       (wb_rd),
    .i_wb_data     (wb_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .ex_mem        (ex_mem.producer)
  );

  memory_stage i_memory_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .ex_mem       (ex_mem.consumer),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .i_dmem_rdata (i_dmem_rdata),
    .o_wb_we      (wb_we),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data)
  );

endmodule

// ==== tb/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// RV32I instruction encoders
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] lw_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
  return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] sw_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// f3 is 000 for BEQ and 001 for BNE
function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic alu_program();
  logic [11:0] a;
  logic [11:0] b;
  logic [19:0] u;
  logic [31:0] va;
  logic [31:0] vb;
  logic [31:0] res [1:10];
  a = 12'($urandom());
  b = 12'($urandom());
  u = 20'($urandom());
  va = sext12(a);
  vb = sext12(b);
  res[1]  = va;
  res[2]  = vb;
  res[3]  = {u, 12'h000};
  res[4]  = va + vb;
  res[5]  = va - vb;
  res[6]  = va & vb;
  res[7]  = va | vb;
  res[8]  = va ^ vb;
  res[9]  = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
  res[10] = ($signed(vb) < $signed(va)) ? 32'd1 : 32'd0;
  emit(addi_inst(5'd1, 5'd0, a));
  emit(addi_inst(5'd2, 5'd0, b));
  emit(lui_inst(5'd3, u));
  emit(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
  emit(r_type(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
  emit(r_type(7'h00, 3'b111, 5'd6, 5'd1, 5'd2));
  emit(r_type(7'h00, 3'b110, 5'd7, 5'd1, 5'd2));
  emit(r_type(7'h00, 3'b100, 5'd8, 5'd1, 5'd2));
  emit(r_type(7'h00, 3'b010, 5'd9, 5'd1, 5'd2));
  emit(r_type(7'h00, 3'b010, 5'd10, 5'd2, 5'd1));
  for (int r = 1; r <= 10; r++) begin
    store_at(5'(r), 12'(12'h040 + 4 * (r - 1)), res[r]);
  end
  finish_program();
endtask

task automatic forwarding_program();
  logic [11:0] c;
  logic [11:0] d;
  logic [31:0] sum;
  c = 12'($urandom());
  d = 12'($urandom());
  sum = sext12(c) + sext12(d);
  // Back-to-back
  emit(addi_inst(5'd1, 5'd0, c));
  emit(addi_inst(5'd2, 5'd1, d));
  // One apart
  emit(addi_inst(5'd5, 5'd0, c));
  emit(addi_inst(5'd6, 5'd0, d));
  emit(addi_inst(5'd7, 5'd5, d));
  // Three apart, through the register file bypass
  emit(addi_inst(5'd8, 5'd0, c));
  emit(addi_inst(5'd0, 5'd0, 12'h000));
  emit(addi_inst(5'd0, 5'd0, 12'h000));
  emit(addi_inst(5'd9, 5'd8, d));
  emit(r_type(7'h00, 3'b000, 5'd10, 5'd2, 5'd7));
  store_at(5'd10, 12'h040, sum + sum);
  store_at(5'd2, 12'h044, sum);
  store_at(5'd7, 12'h048, sum);
  store_at(5'd9, 12'h04c, sum);
  finish_program();
endtask

task automatic load_use_program();
  logic [11:0] e;
  logic [11:0] f;
  e = 12'($urandom());
  f = 12'($urandom());
  emit(addi_inst(5'd1, 5'd0, e));
  emit(addi_inst(5'd4, 5'd0, f));
  store_at(5'd1, 12'h080, sext12(e));
  emit(lw_inst(5'd2, 5'd0, 12'h080));
  emit(r_type(7'h00, 3'b000, 5'd3, 5'd2, 5'd4));
  store_at(5'd3, 12'h040, sext12(e) + sext12(f));
  // Loaded value used as store data
  emit(lw_inst(5'd5, 5'd0, 12'h084));
  store_at(5'd5, 12'h044, dmem_fill(12'h084 >> 2));
  finish_program();
endtask

task automatic branch_program();
  logic [11:0] g;
  logic [31:0] pc_jal;
  g = 12'($urandom());
  emit(addi_inst(5'd1, 5'd0, g));
  emit(addi_inst(5'd2, 5'd0, g));
  emit(addi_inst(5'd3, 5'd0, g ^ 12'h001));
  emit(branch_inst(3'b000, 5'd1, 5'd2, 13'd12));
  emit(sw_inst(5'd3, 5'd0, 12'h040));
  emit(sw_inst(5'd3, 5'd0, 12'h044));
  store_at(5'd1, 12'h048, sext12(g));
  emit(branch_inst(3'b001, 5'd1, 5'd3, 13'd12));
  emit(sw_inst(5'd3, 5'd0, 12'h04c));
  emit(sw_inst(5'd3, 5'd0, 12'h050));
  store_at(5'd2, 12'h054, sext12(g));
  // Not taken, falls into the store
  emit(branch_inst(3'b000, 5'd1, 5'd3, 13'd8));
  store_at(5'd3, 12'h058, sext12(g ^ 12'h001));
  pc_jal = prog_len * 4;
  emit(jal_inst(5'd5, 21'd12));
  emit(sw_inst(5'd3, 5'd0, 12'h060));
  emit(sw_inst(5'd3, 5'd0, 12'h064));
  store_at(5'd5, 12'h068, pc_jal + 32'd4);
  finish_program();
endtask

task automatic zero_reg_program();
  logic [11:0] h;
  h = 12'($urandom()) | 12'h001;
  emit(addi_inst(5'd0, 5'd0, h));
  store_at(5'd0, 12'h040, 32'd0);
  emit(lui_inst(5'd0, 20'($urandom())));
  emit(r_type(7'h00, 3'b000, 5'd1, 5'd0, 5'd0));
  store_at(5'd1, 12'h044, 32'd0);
  emit(lw_inst(5'd0, 5'd0, 12'h084));
  store_at(5'd0, 12'h048, 32'd0);
  emit(addi_inst(5'd2, 5'd0, h));
  store_at(5'd2, 12'h04c, sext12(h));
  finish_program();
endtask

`endif

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic        dmem_we;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  // Expected stores as {address, data} in program order
  logic [63:0] exp_q [$];
  logic        exp_valid;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;

  logic  store_done;
  logic  timed_out;
  logic  rst_held = 1'b0;
  int    prog_len;
  int    errors;
  int    passed;
  int    failed;
  string test_name;

  rv_core i_rv_core (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Both memories are word addressed and read combinationally
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] dmem_fill(input int idx);
    return 32'hd00d_0000 | 32'(idx);
  endfunction

  task automatic emit(input logic [31:0] inst);
    imem[prog_len] = inst;
    prog_len++;
  endtask

  task automatic refresh_head();
    exp_valid = (exp_q.size() > 0);
    if (exp_valid) begin
      exp_addr = exp_q[0][63:32];
      exp_data = exp_q[0][31:0];
    end
  endtask

  // Emits sw rs2, addr(x0) and records the store it must produce
  task automatic store_at(input logic [4:0] rs2, input logic [11:0] addr,
                          input logic [31:0] data);
    emit(sw_inst(rs2, 5'd0, addr));
    exp_q.push_back({20'h00000, addr, data});
  endtask

  `include "tb_programs.svh"

  task automatic finish_program();
    store_at(5'd0, 12'h100, 32'd0);
  endtask

  always @(posedge clk) begin
    rst_held <= !rst_n;
  end

  // Retire the head entry on every store
  always @(posedge clk) begin
    if (rst_n && dmem_we === 1'b1) begin
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      refresh_head();
      if (dmem_addr == 32'h100) begin
        store_done = 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) (!rst_n && rst_held) |-> !dmem_we)
    else begin
      $display("Data memory write during reset in test %s", test_name);
      errors++;
    end

  // Fetch sits at the reset vector while reset is held
  a_reset_pc: assert property (@(posedge clk) (!rst_n && rst_held) |-> imem_addr == 32'h0)
    else begin
      $display("[FAIL] %s expected pc %h actual pc %h", test_name, 32'h0,
               $sampled(imem_addr));
      errors++;
    end

  a_store_expected: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> exp_valid)
    else begin
      $display("Extra store to %h in test %s", $sampled(dmem_addr), test_name);
      errors++;
    end

  a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_we && exp_valid) |-> (dmem_addr == exp_addr && dmem_wdata == exp_data))
    else begin
      $display("[FAIL] %s expected [%h]=%h actual [%h]=%h", test_name,
               $sampled(exp_addr), $sampled(exp_data),
               $sampled(dmem_addr), $sampled(dmem_wdata));
      errors++;
    end

  task automatic run_test(input string name, input int which);
    int start_errors;
    int cycles;
    int limit;
    if (timed_out) begin
      return;
    end
    test_name = name;
    start_errors = errors;
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = addi_inst(5'd0, 5'd0, 12'(i));
      dmem[i] = dmem_fill(i);
    end
    exp_q.delete();
    prog_len = 0;
    store_done = 1'b0;
    case (which)
      1: alu_program();
      2: forwarding_program();
      3: load_use_program();
      4: branch_program();
      default: zero_reg_program();
    endcase
    refresh_head();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    limit = 8 * prog_len + 20;
    cycles = 0;
    while (!store_done && cycles < limit) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!store_done) begin
      $display("Timeout in test %s: no store to 0x100 after %0d cycles", name, cycles);
      timed_out = 1'b1;
      failed++;
    end else begin
      a_queue_drained: assert (exp_q.size() == 0)
        else begin
          $display("Test %s ended with %0d stores missing", name, exp_q.size());
          errors++;
        end
      if (errors == start_errors) begin
        passed++;
        $display("%-12s ok after %0d cycles", name, cycles);
      end else begin
        failed++;
        $display("%-12s failed with %0d errors", name, errors - start_errors);
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    errors = 0;
    passed = 0;
    failed = 0;
    prog_len = 0;
    store_done = 1'b0;
    timed_out = 1'b0;
    exp_valid = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    test_name = "startup";
    void'($urandom(32'h2605_47bf));
    @(posedge clk);
    #2;
    run_test("alu_imm", 1);
    run_test("forwarding", 2);
    run_test("load_use", 3);
    run_test("branch_jal", 4);
    run_test("x0_writes", 5);
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
